//--- motorRtWrite.f
source/motorPkg.sv
source/rtHostPort.sv
source/rtBlockWriter.sv
source/dacChannelBank.sv
source/powerControl.sv
source/motorWriteTop.sv
testbench/motorWriteTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the motor write path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module motorWriteTb -f motorRtWrite.f -o motorSim \
   && ./obj_dir/motorSim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Result: build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Result: fail"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Result: no verdict in log"; exit 1; }
echo "Result: pass"
exit 0

//--- source/dacChannelBank.sv
/* DAC bank on the local bus. Stages one quadlet per channel and loads the
   valid channels together on the block commit. */
`default_nettype none

module dacChannelBank (
   input  wire                    clk,
   input  wire                    reset,
   input  motorPkg::localBus_t    bus,
   output logic [motorPkg::numMotors-1:0][motorPkg::dacValueWidth-1:0] dacValue,
   output logic [motorPkg::numMotors-1:0] dacUpdate,
   output motorPkg::ampRequest_t  ampRequest
);

   logic [31:0] stageData [motorPkg::numMotors];
   logic [motorPkg::numMotors-1:0] staged;
   logic [motorPkg::chanWidth-1:0] stageIdx;
   logic stageHit;
   logic commit;

   // Commit is a block strobe without a register strobe
   assign commit = bus.writeEn && bus.blkWen && !bus.regWen;

   // DAC register of channel 1..numMotors, high nibble is channel plus one
   assign stageHit = bus.writeEn && bus.regWen && !bus.blkWen &&
                     (bus.addr[3:0] == motorPkg::dacOffset) &&
                     (bus.addr[7:4] != 4'd0) &&
                     (bus.addr[7:4] <= 4'(motorPkg::numMotors));
   assign stageIdx = (motorPkg::chanWidth)'(bus.addr[7:4] - 4'd1);

   // Staged flags, dropped at block start and after the commit
   always_ff @(posedge clk) begin
      if (reset) begin
         staged <= '0;
      end else if (bus.blkStart || commit) begin
         staged <= '0;
      end else if (stageHit) begin
         staged[stageIdx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (stageHit) begin
         stageData[stageIdx] <= bus.data;
      end
   end

   // Load the valid channels, one update pulse each
   always_ff @(posedge clk) begin
      if (reset) begin
         dacValue <= '0;
         dacUpdate <= '0;
      end else begin
         dacUpdate <= '0;
         if (commit) begin
            for (int i = 0; i < motorPkg::numMotors; i++) begin
               if (staged[i] && stageData[i][motorPkg::dacValidBit]) begin
                  dacValue[i] <= stageData[i][motorPkg::dacValueWidth-1:0];
                  dacUpdate[i] <= 1'b1;
               end
            end
         end
      end
   end

   // Amp requests go to power control in the commit cycle only
   always_comb begin
      for (int i = 0; i < motorPkg::numMotors; i++) begin
         ampRequest.mask[i] = commit && staged[i] && stageData[i][motorPkg::ampMaskBit];
         ampRequest.value[i] = commit && staged[i] && stageData[i][motorPkg::ampValueBit];
      end
   end

endmodule

`default_nettype wire

//--- source/motorPkg.sv
/* Board constants, quadlet field positions and bus types for the motor write path.
   Modules refer to these by scoped names. */
`default_nettype none

package motorPkg;

   // Board size
   localparam int numMotors = 4;
   localparam int chanWidth = $clog2(numMotors);
   localparam logic [chanWidth-1:0] lastChan = chanWidth'(numMotors - 1);

   // Block quadlet index, the power quadlet follows the DAC quadlets
   localparam int rtAddrWidth = 4;
   localparam logic [rtAddrWidth-1:0] ctrlQuadIndex = rtAddrWidth'(numMotors);

   // Host bus addressing
   localparam int axiAddrWidth = 8;
   localparam logic [axiAddrWidth-1:0] statusAddr = 'h20;

   // Local bus register offset of the DAC register
   localparam logic [3:0] dacOffset = 4'd1;

   // DAC quadlet fields
   localparam int dacValidBit = 31;
   localparam int ampMaskBit = 29;
   localparam int ampValueBit = 28;
   localparam int dacValueWidth = 16;

   // Power quadlet, only the low bits are kept
   localparam int ctrlWidth = 20;
   localparam int ampValuePos = 0;
   localparam int ampMaskPos = 8;
   localparam int boardPowerMaskPos = 18;
   localparam int boardPowerValuePos = 19;

   // One block quadlet from the host port
   typedef struct packed {
      logic en;
      logic [rtAddrWidth-1:0] addr;
      logic [31:0] data;
   } rtWrite_t;

   // Board local register bus
   typedef struct packed {
      logic writeEn;
      logic blkStart;
      logic regWen;
      logic blkWen;
      logic [7:0] addr;
      logic [31:0] data;
   } localBus_t;

   // Amplifier requests carried by the DAC quadlets
   typedef struct packed {
      logic [numMotors-1:0] mask;
      logic [numMotors-1:0] value;
   } ampRequest_t;

endpackage

`default_nettype wire

//--- source/motorWriteTop.sv
/* Top of the real-time write path: host port, block writer, DAC bank and
   power control joined by the local bus. */
`default_nettype none

module motorWriteTop (
   input  wire                                 clk,
   input  wire                                 reset,
   input  wire                                 awvalid,
   output logic                                awready,
   input  wire  [motorPkg::axiAddrWidth-1:0]   awaddr,
   input  wire                                 wvalid,
   output logic                                wready,
   input  wire  [31:0]                         wdata,
   input  wire  [3:0]                          wstrb,
   output logic                                bvalid,
   input  wire                                 bready,
   output logic [1:0]                          bresp,
   input  wire                                 arvalid,
   output logic                                arready,
   input  wire  [motorPkg::axiAddrWidth-1:0]   araddr,
   output logic                                rvalid,
   input  wire                                 rready,
   output logic [31:0]                         rdata,
   output logic [1:0]                          rresp,
   output logic [motorPkg::numMotors-1:0][motorPkg::dacValueWidth-1:0] dacValue,
   output logic [motorPkg::numMotors-1:0]      dacUpdate,
   output logic [motorPkg::numMotors-1:0]      ampEnable,
   output logic                                boardPower
);

   motorPkg::rtWrite_t rtWrite;
   motorPkg::localBus_t localBus;
   motorPkg::ampRequest_t ampRequest;
   logic busy;

   rtHostPort hostPort (
      .clk, .reset, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
      .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
      .rdata, .rresp, .rtWrite, .busy, .ampEnable, .boardPower
   );

   rtBlockWriter blockWriter (.clk, .reset, .rtWrite, .bus(localBus), .busy);

   dacChannelBank dacBank (.clk, .reset, .bus(localBus), .dacValue, .dacUpdate, .ampRequest);

   powerControl power (.clk, .reset, .bus(localBus), .ampRequest, .ampEnable, .boardPower);

endmodule

`default_nettype wire

//--- source/powerControl.sv
/* Power control register on the local bus. Holds amplifier enables and board
   power; DAC commits and the power quadlet both update them. */
`default_nettype none

module powerControl (
   input  wire                              clk,
   input  wire                              reset,
   input  motorPkg::localBus_t              bus,
   input  motorPkg::ampRequest_t            ampRequest,
   output logic [motorPkg::numMotors-1:0]   ampEnable,
   output logic                             boardPower
);

   logic commit;
   logic quadWrite;

   // Both strobes together mark the power quadlet
   assign commit = bus.writeEn && bus.blkWen && !bus.regWen;
   assign quadWrite = bus.writeEn && bus.regWen && bus.blkWen;

   always_ff @(posedge clk) begin
      if (reset) begin
         ampEnable <= '0;
         boardPower <= 1'b0;
      end else begin
         // Requests forwarded by the DAC bank
         if (commit) begin
            for (int i = 0; i < motorPkg::numMotors; i++) begin
               if (ampRequest.mask[i]) begin
                  ampEnable[i] <= ampRequest.value[i];
               end
            end
         end
         // Masked update from the power quadlet
         if (quadWrite) begin
            for (int i = 0; i < motorPkg::numMotors; i++) begin
               if (bus.data[motorPkg::ampMaskPos + i]) begin
                  ampEnable[i] <= bus.data[motorPkg::ampValuePos + i];
               end
            end
            if (bus.data[motorPkg::boardPowerMaskPos]) begin
               boardPower <= bus.data[motorPkg::boardPowerValuePos];
            end
         end
      end
   end

   // Power quadlet only ever targets register 0
   quadAtZero: assert property (@(posedge clk) disable iff (reset)
      (bus.regWen && bus.blkWen) |-> (bus.addr == 8'd0));

endmodule

`default_nettype wire

//--- source/rtBlockWriter.sv
/* Stores a real-time block and replays it as timed writes on the local bus.
   The power quadlet index starts the sequence; busy covers it until idle. */
`default_nettype none

module rtBlockWriter (
   input  wire                   clk,
   input  wire                   reset,
   input  motorPkg::rtWrite_t    rtWrite,
   output motorPkg::localBus_t   bus,
   output logic                  busy
);

   typedef enum logic [2:0] {
      stIdle,
      stStart,
      stWrite,
      stGap,
      stBlkWait,
      stQuadGap,
      stQuad
   } state_t;

   state_t state;
   logic [1:0] gapCnt;
   logic [motorPkg::chanWidth-1:0] chan;
   logic [motorPkg::chanWidth-1:0] nextChan;
   logic [31:0] dacStore [motorPkg::numMotors];
   logic [motorPkg::ctrlWidth-1:0] ctrlStore;
   logic anyActive;
   logic lastQuad;

   // Local bus address of a channel's DAC register
   function automatic logic [7:0] chanAddr(input logic [motorPkg::chanWidth-1:0] ch);
      return {4'(ch) + 4'd1, motorPkg::dacOffset};
   endfunction

   assign nextChan = chan + 1'b1;
   assign lastQuad = (rtWrite.addr == motorPkg::ctrlQuadIndex);
   assign busy = (state != stIdle);

   // Any channel with a DAC value or an amp request pending
   always_comb begin
      anyActive = 1'b0;
      for (int i = 0; i < motorPkg::numMotors; i++) begin
         anyActive |= dacStore[i][motorPkg::dacValidBit] | dacStore[i][motorPkg::ampMaskBit];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= stIdle;
         gapCnt <= 2'd0;
         chan <= '0;
         bus.writeEn <= 1'b0;
         bus.blkStart <= 1'b0;
         bus.regWen <= 1'b0;
         bus.blkWen <= 1'b0;
         // Stored data may stay, the pending flags may not
         for (int i = 0; i < motorPkg::numMotors; i++) begin
            dacStore[i][motorPkg::dacValidBit] <= 1'b0;
            dacStore[i][motorPkg::ampMaskBit] <= 1'b0;
         end
      end else begin
         // Free running gap counter, held at zero while idle
         gapCnt <= (state == stIdle) ? 2'd0 : gapCnt + 2'd1;

         case (state)
            stIdle: begin
               if (rtWrite.en) begin
                  if (lastQuad) begin
                     ctrlStore <= rtWrite.data[motorPkg::ctrlWidth-1:0];
                     bus.writeEn <= 1'b1;
                     if (anyActive) begin
                        // Block start held for four cycles
                        bus.blkStart <= 1'b1;
                        state <= stStart;
                     end else begin
                        // Nothing for the DACs, power quadlet goes out next cycle
                        bus.regWen <= 1'b1;
                        bus.blkWen <= 1'b1;
                        bus.addr <= 8'd0;
                        bus.data <= 32'(rtWrite.data[motorPkg::ctrlWidth-1:0]);
                        state <= stQuad;
                     end
                  end else begin
                     dacStore[rtWrite.addr[motorPkg::chanWidth-1:0]] <= rtWrite.data;
                  end
               end
            end

            stStart: begin
               if (gapCnt == 2'd3) begin
                  // First channel write follows the start strobe directly
                  bus.blkStart <= 1'b0;
                  bus.regWen <= 1'b1;
                  bus.addr <= chanAddr('0);
                  bus.data <= dacStore[0];
                  chan <= '0;
                  state <= stWrite;
               end
            end

            stWrite: begin
               bus.regWen <= 1'b0;
               // Written channel is no longer pending
               dacStore[chan][motorPkg::dacValidBit] <= 1'b0;
               dacStore[chan][motorPkg::ampMaskBit] <= 1'b0;
               state <= stGap;
            end

            stGap: begin
               // Three idle cycles between channel writes
               if (gapCnt == 2'd3) begin
                  if (chan == motorPkg::lastChan) begin
                     state <= stBlkWait;
                  end else begin
                     chan <= nextChan;
                     bus.regWen <= 1'b1;
                     bus.addr <= chanAddr(nextChan);
                     bus.data <= dacStore[nextChan];
                     state <= stWrite;
                  end
               end
            end

            stBlkWait: begin
               // Commit one slot after the last channel
               if (gapCnt == 2'd3) begin
                  bus.blkWen <= 1'b1;
                  state <= stQuadGap;
               end
            end

            stQuadGap: begin
               if (bus.blkWen) begin
                  // Commit cycle, restart the gap count for the power write
                  bus.blkWen <= 1'b0;
                  gapCnt <= 2'd0;
                  if (ctrlStore == '0) begin
                     bus.writeEn <= 1'b0;
                     state <= stIdle;
                  end
               end else if (gapCnt == 2'd3) begin
                  bus.regWen <= 1'b1;
                  bus.blkWen <= 1'b1;
                  bus.addr <= 8'd0;
                  bus.data <= 32'(ctrlStore);
                  state <= stQuad;
               end
            end

            stQuad: begin
               // Power quadlet is on the bus this cycle
               bus.regWen <= 1'b0;
               bus.blkWen <= 1'b0;
               bus.writeEn <= 1'b0;
               state <= stIdle;
            end

            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

   // Targets need a quiet cycle after every register write
   regWenSpaced: assert property (@(posedge clk) disable iff (reset)
      bus.regWen |=> !bus.regWen);

   // No register traffic while the start strobe is up
   startNoWrite: assert property (@(posedge clk) disable iff (reset)
      !(bus.blkStart && bus.regWen));

endmodule

`default_nettype wire

//--- source/rtHostPort.sv
/* AXI4-Lite slave for the real-time block. Each accepted quadlet becomes one
   rtWrite pulse; reads return the status word. */
`default_nettype none

module rtHostPort (
   input  wire                                 clk,
   input  wire                                 reset,
   // Write address and data
   input  wire                                 awvalid,
   output logic                                awready,
   input  wire  [motorPkg::axiAddrWidth-1:0]   awaddr,
   input  wire                                 wvalid,
   output logic                                wready,
   input  wire  [31:0]                         wdata,
   input  wire  [3:0]                          wstrb,
   // Write response
   output logic                                bvalid,
   input  wire                                 bready,
   output logic [1:0]                          bresp,
   // Read channel
   input  wire                                 arvalid,
   output logic                                arready,
   input  wire  [motorPkg::axiAddrWidth-1:0]   araddr,
   output logic                                rvalid,
   input  wire                                 rready,
   output logic [31:0]                         rdata,
   output logic [1:0]                          rresp,
   // Block writer side
   output motorPkg::rtWrite_t                  rtWrite,
   input  wire                                 busy,
   input  wire  [motorPkg::numMotors-1:0]      ampEnable,
   input  wire                                 boardPower
);

   logic accept;
   logic inRange;
   logic readAccept;
   logic [31:0] maskedData;
   logic [31:0] statusWord;

   // Address and data are taken together
   // Stalled while the writer is busy or a response is pending
   assign awready = !busy && !bvalid;
   assign wready = awready;
   assign accept = awvalid && wvalid && awready;

   // Quadlet k sits at byte address 4k, k up to the power quadlet
   assign inRange = (awaddr[1:0] == 2'b00) &&
                    (awaddr[motorPkg::axiAddrWidth-1:motorPkg::rtAddrWidth+2] == '0) &&
                    (awaddr[motorPkg::rtAddrWidth+1:2] <= motorPkg::ctrlQuadIndex);

   // Bytes without a strobe read as zero
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         maskedData[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : 8'h00;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rtWrite.en <= 1'b0;
      end else begin
         // Out of range writes are answered but dropped
         rtWrite.en <= accept && inRange;
         if (accept) begin
            rtWrite.addr <= awaddr[motorPkg::rtAddrWidth+1:2];
            rtWrite.data <= maskedData;
         end
      end
   end

   // Write response, always OKAY
   assign bresp = 2'b00;

   always_ff @(posedge clk) begin
      if (reset) begin
         bvalid <= 1'b0;
      end else if (accept) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   // Status word: busy, board power, amplifier enables
   always_comb begin
      statusWord = '0;
      statusWord[31] = busy;
      statusWord[16] = boardPower;
      statusWord[motorPkg::numMotors-1:0] = ampEnable;
   end

   // One read outstanding at a time
   assign arready = !rvalid;
   assign readAccept = arvalid && arready;
   assign rresp = 2'b00;

   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid <= 1'b0;
      end else if (readAccept) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   // Anything but the status address reads zero
   always_ff @(posedge clk) begin
      if (readAccept) begin
         rdata <= (araddr == motorPkg::statusAddr) ? statusWord : 32'd0;
      end
   end

   // A quadlet must never reach the writer during a running sequence
   noWriteWhileBusy: assert property (@(posedge clk) disable iff (reset)
      rtWrite.en |-> !busy);

endmodule

`default_nettype wire

//--- testbench/motorWriteTb.sv
/* Testbench for the real-time motor write path. Sends random blocks over AXI4-Lite
   and compares DAC, amplifier and board power outputs against a reference model. */
`default_nettype none

module motorWriteTb;

   logic clk;
   logic reset;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [motorPkg::axiAddrWidth-1:0] awaddr;
   logic [motorPkg::axiAddrWidth-1:0] araddr;
   logic [31:0] wdata;
   logic [31:0] rdata;
   logic [3:0] wstrb;
   logic [1:0] bresp;
   logic [1:0] rresp;
   logic [motorPkg::numMotors-1:0][motorPkg::dacValueWidth-1:0] dacValue;
   logic [motorPkg::numMotors-1:0] dacUpdate;
   logic [motorPkg::numMotors-1:0] ampEnable;
   logic boardPower;

   // Reference model state
   logic [31:0] modelStore [motorPkg::numMotors];
   logic [motorPkg::dacValueWidth-1:0] expDac [motorPkg::numMotors];
   int expPulse [motorPkg::numMotors];
   int pulseCount [motorPkg::numMotors];
   logic [motorPkg::numMotors-1:0] expAmp;
   logic expBoard;

   int seed;
   int errorCount;
   int checkCount;
   string testName;

   motorWriteTop DUT (
      .clk, .reset, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
      .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
      .rdata, .rresp, .dacValue, .dacUpdate, .ampEnable, .boardPower
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Count update pulses mid cycle, away from the clock edge
   always @(negedge clk) begin
      for (int i = 0; i < motorPkg::numMotors; i++) begin
         if (dacUpdate[i]) pulseCount[i]++;
      end
   end

   task automatic finishRun();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   task automatic timeoutFail(input string what);
      $display("Timeout in test %s: %s", testName, what);
      errorCount++;
      finishRun();
   endtask

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      assert (expected == actual) else begin
         errorCount++;
         $display("ERROR %s %s: expected %h actual %h", testName, what, expected, actual);
      end
   endtask

   // One AXI write, address and data together, then a delayed B handshake
   task automatic writeQuad(input logic [motorPkg::axiAddrWidth-1:0] addr,
                            input logic [31:0] data);
      int waitCount;
      int delay;
      awaddr = addr;
      wdata = data;
      wstrb = 4'hf;
      awvalid = 1'b1;
      wvalid = 1'b1;
      waitCount = 0;
      while (!awready && waitCount < 200) begin
         @(posedge clk);
         #1;
         waitCount++;
      end
      if (!awready) timeoutFail("write was never accepted");
      // Data channel is ready together with the address channel
      checkValue("wready", 32'd1, 32'(wready));
      // Handshake on this edge
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      waitCount = 0;
      while (!bvalid && waitCount < 200) begin
         @(posedge clk);
         #1;
         waitCount++;
      end
      if (!bvalid) timeoutFail("no write response arrived");
      checkValue("bresp", 32'd0, 32'(bresp));
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
         @(posedge clk);
         #1;
      end
      bready = 1'b1;
      @(posedge clk);
      #1;
      bready = 1'b0;
   endtask

   // Status read, rready stays high so the data lasts one cycle
   task automatic readStatus(output logic [31:0] status);
      int waitCount;
      araddr = motorPkg::statusAddr;
      arvalid = 1'b1;
      waitCount = 0;
      while (!arready && waitCount < 200) begin
         @(posedge clk);
         #1;
         waitCount++;
      end
      if (!arready) timeoutFail("status read was never accepted");
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      waitCount = 0;
      while (!rvalid && waitCount < 200) begin
         @(posedge clk);
         #1;
         waitCount++;
      end
      if (!rvalid) timeoutFail("no status read data arrived");
      checkValue("rresp", 32'd0, 32'(rresp));
      status = rdata;
      @(posedge clk);
      #1;
   endtask

   task automatic waitIdle(output logic [31:0] status);
      int polls;
      polls = 0;
      readStatus(status);
      while (status[31] && polls < 100) begin
         readStatus(status);
         polls++;
      end
      if (status[31]) timeoutFail("busy never cleared after the block");
   endtask

   // Masked update from the kept power bits
   function automatic void applyPower(input logic [motorPkg::ctrlWidth-1:0] ctrl);
      for (int i = 0; i < motorPkg::numMotors; i++) begin
         if (ctrl[motorPkg::ampMaskPos + i]) expAmp[i] = ctrl[motorPkg::ampValuePos + i];
      end
      if (ctrl[motorPkg::boardPowerMaskPos]) expBoard = ctrl[motorPkg::boardPowerValuePos];
   endfunction

   // Commit of the pending channels first, power quadlet after it
   function automatic void applyModel(input logic [31:0] powerQuad);
      logic [motorPkg::ctrlWidth-1:0] ctrl;
      logic active;
      ctrl = powerQuad[motorPkg::ctrlWidth-1:0];
      active = 1'b0;
      for (int c = 0; c < motorPkg::numMotors; c++) begin
         active |= modelStore[c][motorPkg::dacValidBit] | modelStore[c][motorPkg::ampMaskBit];
      end
      if (active) begin
         for (int c = 0; c < motorPkg::numMotors; c++) begin
            if (modelStore[c][motorPkg::dacValidBit]) begin
               expDac[c] = modelStore[c][motorPkg::dacValueWidth-1:0];
               expPulse[c]++;
            end
            if (modelStore[c][motorPkg::ampMaskBit]) begin
               expAmp[c] = modelStore[c][motorPkg::ampValueBit];
            end
            // Written channels are no longer pending
            modelStore[c][motorPkg::dacValidBit] = 1'b0;
            modelStore[c][motorPkg::ampMaskBit] = 1'b0;
         end
      end
      if (!active || ctrl != '0) applyPower(ctrl);
   endfunction

   task automatic sendBlock(input logic [motorPkg::numMotors-1:0] validSel,
                            input logic [motorPkg::numMotors-1:0] maskSel,
                            input logic [31:0] powerQuad);
      logic [31:0] quad;
      for (int c = 0; c < motorPkg::numMotors; c++) begin
         quad = $random(seed);
         quad[motorPkg::dacValidBit] = validSel[c];
         quad[motorPkg::ampMaskBit] = maskSel[c];
         writeQuad(8'(4 * c), quad);
         modelStore[c] = quad;
      end
      // Power quadlet triggers the sequence
      writeQuad(8'(4 * motorPkg::numMotors), powerQuad);
      applyModel(powerQuad);
   endtask

   task automatic checkOutputs();
      logic [31:0] status;
      waitIdle(status);
      for (int c = 0; c < motorPkg::numMotors; c++) begin
         checkValue($sformatf("dacValue[%0d]", c), 32'(expDac[c]), 32'(dacValue[c]));
         checkValue($sformatf("dacUpdate count[%0d]", c), 32'(expPulse[c]),
                    32'(pulseCount[c]));
      end
      checkValue("ampEnable", 32'(expAmp), 32'(ampEnable));
      checkValue("boardPower", 32'(expBoard), 32'(boardPower));
      checkValue("status amp", 32'(expAmp), 32'(status[motorPkg::numMotors-1:0]));
      checkValue("status power", 32'(expBoard), 32'(status[16]));
   endtask

   initial begin
      seed = 34214;
      errorCount = 0;
      checkCount = 0;
      testName = "reset";
      reset = 1'b1;
      awvalid = 1'b0;
      awaddr = '0;
      wvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      bready = 1'b0;
      arvalid = 1'b0;
      araddr = '0;
      rready = 1'b1;
      expAmp = '0;
      expBoard = 1'b0;
      for (int c = 0; c < motorPkg::numMotors; c++) begin
         modelStore[c] = '0;
         expDac[c] = '0;
         expPulse[c] = 0;
      end
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      checkValue("bvalid", 32'd0, 32'(bvalid));
      checkValue("rvalid", 32'd0, 32'(rvalid));
      checkOutputs();

      testName = "fullBlock";
      sendBlock('1, '0, 32'd0);
      checkOutputs();

      testName = "partialBlock";
      repeat (3) begin
         sendBlock((motorPkg::numMotors)'($random(seed)), '0, 32'd0);
         checkOutputs();
      end

      // Upper power bits are random too and must be ignored
      testName = "powerOnly";
      repeat (4) begin
         sendBlock('0, '0, $random(seed));
         checkOutputs();
      end

      testName = "ordering";
      repeat (4) begin
         sendBlock((motorPkg::numMotors)'($random(seed)),
                   (motorPkg::numMotors)'($random(seed)), $random(seed));
         checkOutputs();
      end

      // Blocks back to back, each stalls until the previous one is done
      testName = "backPressure";
      repeat (6) begin
         sendBlock((motorPkg::numMotors)'($random(seed)),
                   (motorPkg::numMotors)'($random(seed)), $random(seed));
      end
      checkOutputs();

      testName = "emptyBlock";
      writeQuad(8'h3c, $random(seed));
      sendBlock('0, '0, 32'd0);
      checkOutputs();

      finishRun();
   end

endmodule

`default_nettype wire
